// File: logic/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define ISA_WIDTH            32         // machine word
`define REG_FILE_ADDR_WIDTH  5          // 32 general registers
`define DMEM_ADDR_WIDTH      8          // 256 data words

`define HAZD_CTL_WIDTH       2
`define HAZD_CTL_NORMAL      2'b00      // memory stage takes the next op
`define HAZD_CTL_NO_OP       2'b01      // insert a bubble
`define HAZD_CTL_RETRY       2'b10      // memory stage keeps its op

`define FORW_SEL_WIDTH       2
`define FORW_SEL_INPUT       2'b00      // operand as read upstream
`define FORW_SEL_ALU_RES     2'b01      // result sitting in the memory stage
`define FORW_SEL_MEM_RES     2'b10      // write-back data

`define MEM_WRITE_BIT        1          // store
`define MEM_READ_BIT         0          // load

`define ALU_OP_WIDTH         3
`define ALU_OP_ADD           3'd0
`define ALU_OP_SUB           3'd1
`define ALU_OP_AND           3'd2
`define ALU_OP_OR            3'd3
`define ALU_OP_XOR           3'd4
`define ALU_OP_SLT           3'd5       // signed compare
`define ALU_OP_SLL           3'd6       // shift by b[4:0]
`define ALU_OP_PASS_B        3'd7

`endif

// File: logic/isa_pkg.sv
`include "cpu_consts.svh"

package isa_pkg;

    // one machine word, data and addresses alike
    typedef logic [`ISA_WIDTH-1:0] word_t;

    // general register index
    typedef logic [`REG_FILE_ADDR_WIDTH-1:0] reg_idx_t;

    // alu operation code, values in cpu_consts.svh
    typedef logic [`ALU_OP_WIDTH-1:0] alu_op_t;

endpackage

// File: logic/pipe_pkg.sv
`include "cpu_consts.svh"

package pipe_pkg;

    // next state of the memory stage
    typedef logic [`HAZD_CTL_WIDTH-1:0] hazd_ctl_t;

    // operand source for forwarding
    typedef logic [`FORW_SEL_WIDTH-1:0] forw_sel_t;

    // read and write strobes, bit positions MEM_READ_BIT / MEM_WRITE_BIT
    typedef logic [1:0] mem_ctl_t;

endpackage

// File: logic/alu.sv
`include "cpu_consts.svh"
`timescale 1ns/100ps

module alu
    import isa_pkg::*, pipe_pkg::*;
(
    input  alu_op_t   alu_op,               // from upstream decode
    input  word_t     ex_rs_data,           // rs as read from register file
    input  word_t     ex_rt_data,           // rt as read from register file
    input  forw_sel_t rs_select,            // from forwarding_unit
    input  forw_sel_t rt_select,
    input  word_t     mem_alu_result,       // memory stage result
    input  word_t     wb_reg_write_data,    // write-back data
    output word_t     ex_alu_result,
    output word_t     ex_store_data         // forwarded rt for stores
);

    word_t op_a;                            // forwarded rs
    word_t op_b;                            // forwarded rt

    function automatic word_t forwarded(input forw_sel_t sel, input word_t reg_val,
                                        input word_t mem_val, input word_t wb_val);
        case (sel)
            `FORW_SEL_ALU_RES: return mem_val;
            `FORW_SEL_MEM_RES: return wb_val;
            default:           return reg_val;   // input or unused code
        endcase
    endfunction

    assign op_a = forwarded(rs_select, ex_rs_data, mem_alu_result, wb_reg_write_data);
    assign op_b = forwarded(rt_select, ex_rt_data, mem_alu_result, wb_reg_write_data);

    assign ex_store_data = op_b;

    always_comb begin
        case (alu_op)
            `ALU_OP_ADD: ex_alu_result = op_a + op_b;
            `ALU_OP_SUB: ex_alu_result = op_a - op_b;
            `ALU_OP_AND: ex_alu_result = op_a & op_b;
            `ALU_OP_OR:  ex_alu_result = op_a | op_b;
            `ALU_OP_XOR: ex_alu_result = op_a ^ op_b;
            `ALU_OP_SLT: ex_alu_result = {{(`ISA_WIDTH-1){1'b0}},
                                          $signed(op_a) < $signed(op_b)};
            `ALU_OP_SLL: ex_alu_result = op_a << op_b[4:0];
            default:     ex_alu_result = op_b;  // pass b
        endcase
    end

endmodule

// File: logic/forwarding_unit.sv
`include "cpu_consts.svh"
`timescale 1ns/100ps

module forwarding_unit
    import isa_pkg::*, pipe_pkg::*;
(
    input  reg_idx_t  ex_rs_idx,
    input  reg_idx_t  ex_rt_idx,
    input  reg_idx_t  mem_dest_reg_idx,
    input  logic      mem_reg_write_enable,
    input  mem_ctl_t  mem_mem_control,
    input  logic      mem_no_op,
    input  reg_idx_t  wb_dest_reg_idx,
    input  logic      wb_reg_write_enable,
    output forw_sel_t rs_select,            // to alu
    output forw_sel_t rt_select,            // to alu
    output forw_sel_t store_data_select     // to ex_mem_reg
);

    logic mem_fwd_ok;                       // memory stage has a result ready
    logic wb_fwd_ok;

    // a load's data only exists one stage later, hazard_unit stalls for it
    assign mem_fwd_ok = mem_reg_write_enable && !mem_mem_control[`MEM_READ_BIT] && !mem_no_op;
    assign wb_fwd_ok  = wb_reg_write_enable;

    function automatic forw_sel_t pick_source(input reg_idx_t src, input reg_idx_t mem_dst,
                                              input logic mem_ok, input reg_idx_t wb_dst,
                                              input logic wb_ok);
        if (src == '0)
            return `FORW_SEL_INPUT;         // r0 is never forwarded
        else if (mem_ok && src == mem_dst)
            return `FORW_SEL_ALU_RES;       // youngest producer first
        else if (wb_ok && src == wb_dst)
            return `FORW_SEL_MEM_RES;
        else
            return `FORW_SEL_INPUT;
    endfunction

    assign rs_select = pick_source(ex_rs_idx, mem_dest_reg_idx, mem_fwd_ok,
                                   wb_dest_reg_idx, wb_fwd_ok);
    assign rt_select = pick_source(ex_rt_idx, mem_dest_reg_idx, mem_fwd_ok,
                                   wb_dest_reg_idx, wb_fwd_ok);

    // same choice, applied again at the stage register edge
    assign store_data_select = rt_select;

endmodule

// File: logic/hazard_unit.sv
`include "cpu_consts.svh"
`timescale 1ns/100ps

module hazard_unit
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic      hold,                 // downstream freeze
    input  logic      ex_no_op,
    input  reg_idx_t  ex_rs_idx,
    input  reg_idx_t  ex_rt_idx,
    input  mem_ctl_t  mem_mem_control,
    input  logic      mem_no_op,
    input  reg_idx_t  mem_dest_reg_idx,
    output hazd_ctl_t hazard_control,       // to ex_mem_reg and mem_wb_reg
    output logic      ignore_no_op,
    output logic      ex_stall              // upstream repeats the execute op
);

    logic mem_live_load;
    logic rs_hit;
    logic rt_hit;
    logic load_use;

    assign mem_live_load = mem_mem_control[`MEM_READ_BIT] && !mem_no_op;
    assign rs_hit        = ex_rs_idx != '0 && ex_rs_idx == mem_dest_reg_idx;
    assign rt_hit        = ex_rt_idx != '0 && ex_rt_idx == mem_dest_reg_idx;
    assign load_use      = mem_live_load && !ex_no_op && (rs_hit || rt_hit);

    // hold wins over a load-use bubble
    always_comb begin
        if (hold)
            hazard_control = `HAZD_CTL_RETRY;
        else if (load_use)
            hazard_control = `HAZD_CTL_NO_OP;
        else
            hazard_control = `HAZD_CTL_NORMAL;
    end

    assign ignore_no_op = hold;             // memory stage must keep its op
    assign ex_stall     = hold || load_use;

endmodule

// File: logic/ex_mem_reg.sv
`include "cpu_consts.svh"
`timescale 1ns/100ps

module ex_mem_reg
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  hazd_ctl_t hazard_control,       // from hazard_unit
    input  logic      ignore_no_op,         // from hazard_unit, set while held
    input  logic      ex_no_op,             // execute op is dead
    input  logic      ex_reg_write_enable,
    input  mem_ctl_t  ex_mem_control,
    input  word_t     ex_alu_result,        // from alu
    input  word_t     ex_store_data,        // forwarded rt from alu
    input  word_t     wb_reg_write_data,    // write-back data for store forwarding
    input  forw_sel_t store_data_select,    // from forwarding_unit
    input  reg_idx_t  ex_dest_reg_idx,
    output logic      mem_no_op,
    output logic      mem_reg_write_enable, // to mem_wb_reg and forwarding
    output mem_ctl_t  mem_mem_control,      // to data_mem, mem_wb_reg, hazards
    output word_t     mem_alu_result,       // address for data_mem, forwarded to alu
    output word_t     mem_store_data,       // write data for data_mem
    output reg_idx_t  mem_dest_reg_idx
);

    logic  take_bubble;                     // next memory op is dead
    logic  load_next;                       // normal advance
    word_t store_data_next;

    assign take_bubble = (ex_no_op && !ignore_no_op) || hazard_control == `HAZD_CTL_NO_OP;
    assign load_next   = !take_bubble && hazard_control == `HAZD_CTL_NORMAL;

    // mem_alu_result here is still the op ahead, same value the alu forwarded
    always_comb begin
        case (store_data_select)
            `FORW_SEL_INPUT:   store_data_next = ex_store_data;
            `FORW_SEL_ALU_RES: store_data_next = mem_alu_result;
            `FORW_SEL_MEM_RES: store_data_next = wb_reg_write_data;
            default:           store_data_next = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_no_op            <= 1'b0;
            mem_reg_write_enable <= 1'b0;
            mem_mem_control      <= '0;
        end else if (take_bubble) begin
            mem_no_op            <= 1'b1;
            mem_reg_write_enable <= 1'b0;   // a bubble revived by retry stays harmless
            mem_mem_control      <= '0;
        end else if (hazard_control == `HAZD_CTL_RETRY) begin
            mem_no_op            <= 1'b0;   // keep the op, replay it
        end else begin
            mem_no_op            <= 1'b0;
            mem_reg_write_enable <= ex_reg_write_enable;
            mem_mem_control      <= ex_mem_control;
        end
    end

    always_ff @(posedge clk) begin
        if (load_next) begin
            mem_alu_result   <= ex_alu_result;
            mem_store_data   <= store_data_next;
            mem_dest_reg_idx <= ex_dest_reg_idx;
        end
    end

    hazd_ctl_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        hazard_control inside {`HAZD_CTL_NORMAL, `HAZD_CTL_NO_OP, `HAZD_CTL_RETRY}
    ) else $error("unused hazard control code %b", hazard_control);

endmodule

// File: logic/data_mem.sv
`include "cpu_consts.svh"
`timescale 1ns/100ps

module data_mem
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic     clk,
    input  mem_ctl_t mem_mem_control,
    input  logic     mem_no_op,
    input  word_t    mem_alu_result,        // byte address
    input  word_t    mem_store_data,
    output word_t    read_data              // valid one cycle after the address
);

    word_t                      mem_array [0:(1 << `DMEM_ADDR_WIDTH)-1];
    logic [`DMEM_ADDR_WIDTH-1:0] word_addr;
    logic                       write_en;

    assign word_addr = mem_alu_result[`DMEM_ADDR_WIDTH+1:2];    // drop byte offset
    assign write_en  = mem_mem_control[`MEM_WRITE_BIT] && !mem_no_op;

    always_ff @(posedge clk) begin
        if (write_en)
            mem_array[word_addr] <= mem_store_data;
        read_data <= mem_array[word_addr];  // old data on a same-cycle write
    end

    word_aligned: assert property (
        @(posedge clk)
        (mem_mem_control != '0 && !mem_no_op) |-> mem_alu_result[1:0] == 2'b00
    ) else $error("unaligned data access at %h", mem_alu_result);

endmodule

// File: logic/mem_wb_reg.sv
`include "cpu_consts.svh"
`timescale 1ns/100ps

module mem_wb_reg
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  hazd_ctl_t hazard_control,       // retry freezes this stage
    input  logic      mem_no_op,
    input  logic      mem_reg_write_enable,
    input  mem_ctl_t  mem_mem_control,
    input  word_t     mem_alu_result,
    input  reg_idx_t  mem_dest_reg_idx,
    input  word_t     read_data,            // from data_mem, already one cycle late
    output logic      wb_reg_write_enable,  // to register file and forwarding
    output reg_idx_t  wb_dest_reg_idx,
    output word_t     wb_reg_write_data
);

    logic  retry;
    logic  wb_is_load;                      // pick memory data at write-back
    word_t wb_result;

    assign retry = hazard_control == `HAZD_CTL_RETRY;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_reg_write_enable <= 1'b0;
            wb_is_load          <= 1'b0;
        end else if (retry) begin
            wb_is_load          <= 1'b0;    // load data now parked in wb_result
        end else begin
            wb_reg_write_enable <= mem_reg_write_enable && !mem_no_op;
            wb_is_load          <= mem_mem_control[`MEM_READ_BIT] && !mem_no_op;
        end
    end

    // read_data tracks the memory stage address, so a held load keeps its copy
    always_ff @(posedge clk) begin
        if (retry) begin
            wb_result       <= wb_reg_write_data;
        end else begin
            wb_result       <= mem_alu_result;
            wb_dest_reg_idx <= mem_dest_reg_idx;
        end
    end

    assign wb_reg_write_data = wb_is_load ? read_data : wb_result;

endmodule

// File: logic/ex_mem_stages.sv
`include "cpu_consts.svh"
`timescale 1ns/100ps

module ex_mem_stages
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     hold,                  // downstream freeze
    input  logic     ex_no_op,
    input  alu_op_t  alu_op,
    input  reg_idx_t ex_rs_idx,
    input  reg_idx_t ex_rt_idx,
    input  word_t    ex_rs_data,
    input  word_t    ex_rt_data,
    input  logic     ex_reg_write_enable,
    input  mem_ctl_t ex_mem_control,
    input  reg_idx_t ex_dest_reg_idx,
    output logic     ex_stall,              // upstream repeats this op
    output logic     wb_reg_write_enable,   // register file write port
    output reg_idx_t wb_dest_reg_idx,
    output word_t    wb_reg_write_data
);

    forw_sel_t rs_select;
    forw_sel_t rt_select;
    forw_sel_t store_data_select;
    hazd_ctl_t hazard_control;
    logic      ignore_no_op;
    word_t     ex_alu_result;
    word_t     ex_store_data;
    logic      mem_no_op;
    logic      mem_reg_write_enable;
    mem_ctl_t  mem_mem_control;
    word_t     mem_alu_result;
    word_t     mem_store_data;
    reg_idx_t  mem_dest_reg_idx;
    word_t     read_data;

    alu u_alu (
        .alu_op, .ex_rs_data, .ex_rt_data, .rs_select, .rt_select,
        .mem_alu_result, .wb_reg_write_data, .ex_alu_result, .ex_store_data
    );

    forwarding_unit u_forwarding_unit (
        .ex_rs_idx, .ex_rt_idx, .mem_dest_reg_idx, .mem_reg_write_enable,
        .mem_mem_control, .mem_no_op, .wb_dest_reg_idx, .wb_reg_write_enable,
        .rs_select, .rt_select, .store_data_select
    );

    hazard_unit u_hazard_unit (
        .hold, .ex_no_op, .ex_rs_idx, .ex_rt_idx, .mem_mem_control, .mem_no_op,
        .mem_dest_reg_idx, .hazard_control, .ignore_no_op, .ex_stall
    );

    ex_mem_reg u_ex_mem_reg (
        .clk, .rst_n, .hazard_control, .ignore_no_op, .ex_no_op, .ex_reg_write_enable,
        .ex_mem_control, .ex_alu_result, .ex_store_data, .wb_reg_write_data,
        .store_data_select, .ex_dest_reg_idx, .mem_no_op, .mem_reg_write_enable,
        .mem_mem_control, .mem_alu_result, .mem_store_data, .mem_dest_reg_idx
    );

    data_mem u_data_mem (
        .clk, .mem_mem_control, .mem_no_op, .mem_alu_result, .mem_store_data, .read_data
    );

    mem_wb_reg u_mem_wb_reg (
        .clk, .rst_n, .hazard_control, .mem_no_op, .mem_reg_write_enable,
        .mem_mem_control, .mem_alu_result, .mem_dest_reg_idx, .read_data,
        .wb_reg_write_enable, .wb_dest_reg_idx, .wb_reg_write_data
    );

endmodule

// File: tests/ex_mem_stages_tb.sv
`include "cpu_consts.svh"
`timescale 1ns/100ps

module ex_mem_stages_tb
    import isa_pkg::*, pipe_pkg::*;
();

    localparam int NUM_OPS   = 400;
    localparam int WAIT_MAX  = 20;              // cycles one op may sit stalled
    localparam int DRAIN_MAX = 50;

    logic     clk;
    logic     rst_n;
    logic     hold;
    logic     ex_no_op;
    alu_op_t  alu_op;
    reg_idx_t ex_rs_idx;
    reg_idx_t ex_rt_idx;
    word_t    ex_rs_data;
    word_t    ex_rt_data;
    logic     ex_reg_write_enable;
    mem_ctl_t ex_mem_control;
    reg_idx_t ex_dest_reg_idx;
    logic     ex_stall;
    logic     wb_reg_write_enable;
    reg_idx_t wb_dest_reg_idx;
    word_t    wb_reg_write_data;

    word_t    rf [0:31];                        // upstream register file fed by write-back
    word_t    arch_reg [0:31];                  // program-order reference registers
    word_t    arch_mem [0:255];                 // program-order reference memory
    reg_idx_t dest_q [$];                       // expected write-backs in order
    word_t    data_q [$];
    logic     head_valid;
    reg_idx_t head_dest;
    word_t    head_data;
    logic     held_last;                        // previous edge froze write-back
    logic     last_taken;                       // previous edge accepted the execute op
    logic     mem_live_load;                    // reference view of the memory stage
    reg_idx_t mem_dest;
    logic     exp_stall;
    integer   seed;
    int       hold_left;
    int       load_stalls;
    int       hold_cycles;

    ex_mem_stages UUT (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;                       // 8 ns period

    function automatic word_t alu_ref(input alu_op_t op, input word_t a, input word_t b);
        case (op)
            `ALU_OP_ADD: return a + b;
            `ALU_OP_SUB: return a - b;
            `ALU_OP_AND: return a & b;
            `ALU_OP_OR:  return a | b;
            `ALU_OP_XOR: return a ^ b;
            `ALU_OP_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            `ALU_OP_SLL: return a << b[4:0];
            default:     return b;
        endcase
    endfunction

    task automatic report_error(input string line);
        $display("%s", line);
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    // load-use rule seen from the reference memory stage
    always_comb begin
        exp_stall = hold;
        if (mem_live_load && !ex_no_op &&
            ((ex_rs_idx != '0 && ex_rs_idx == mem_dest) ||
             (ex_rt_idx != '0 && ex_rt_idx == mem_dest)))
            exp_stall = 1'b1;
    end

    always @(posedge clk) begin : scoreboard
        word_t a;
        word_t b;
        word_t res;
        if (rst_n) begin
            if (wb_reg_write_enable && wb_dest_reg_idx != '0)
                rf[wb_dest_reg_idx] = wb_reg_write_data;    // rewrites under hold are idempotent
            if (wb_reg_write_enable && !held_last && dest_q.size() > 0) begin
                void'(dest_q.pop_front());
                void'(data_q.pop_front());
            end
            if (ex_stall && !hold)
                load_stalls++;
            if (hold)
                hold_cycles++;
            last_taken = !ex_stall;
            if (!ex_stall) begin
                a   = arch_reg[ex_rs_idx];
                b   = arch_reg[ex_rt_idx];
                res = alu_ref(alu_op, a, b);
                mem_live_load = !ex_no_op && ex_mem_control[`MEM_READ_BIT];
                mem_dest      = ex_dest_reg_idx;
                if (!ex_no_op) begin
                    if (ex_mem_control[`MEM_WRITE_BIT])
                        arch_mem[res[9:2]] = b;             // store data is rt
                    if (ex_mem_control[`MEM_READ_BIT])
                        res = arch_mem[res[9:2]];
                    if (ex_reg_write_enable) begin
                        dest_q.push_back(ex_dest_reg_idx);
                        data_q.push_back(res);
                        if (ex_dest_reg_idx != '0)
                            arch_reg[ex_dest_reg_idx] = res;
                    end
                end
            end else if (!hold) begin
                mem_live_load = 1'b0;                       // bubble enters memory stage
            end
            held_last <= hold;
            head_valid = dest_q.size() > 0;
            if (head_valid) begin
                head_dest = dest_q[0];
                head_data = data_q[0];
            end
        end
    end

    reset_low: assert property (@(posedge clk)
        $rose(rst_n) |-> !wb_reg_write_enable && !ex_stall)
    else report_error($sformatf("mismatch at %0t: write enable or stall not low after reset",
                                $time));

    wb_value_ok: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_reg_write_enable && !held_last) |->
            (head_valid && wb_dest_reg_idx == head_dest && wb_reg_write_data == head_data))
    else report_error($sformatf("mismatch at %0t: write-back r%0d = %h, expected r%0d = %h",
                                $time, $sampled(wb_dest_reg_idx),
                                $sampled(wb_reg_write_data),
                                $sampled(head_dest), $sampled(head_data)));

    latency_ok: assert property (@(posedge clk) disable iff (!rst_n)
        (!ex_stall && !ex_no_op && ex_reg_write_enable) ##1 !hold |=>
            (wb_reg_write_enable && wb_dest_reg_idx == $past(ex_dest_reg_idx, 2)))
    else report_error($sformatf("mismatch at %0t: op missing at write-back 2 cycles late",
                                $time));

    stall_ok: assert property (@(posedge clk) disable iff (!rst_n) ex_stall == exp_stall)
    else report_error($sformatf("mismatch at %0t: ex_stall %b, expected %b",
                                $time, $sampled(ex_stall), $sampled(exp_stall)));

    single_stall: assert property (@(posedge clk) disable iff (!rst_n)
        (ex_stall && !hold) |=> (!ex_stall || hold))
    else report_error("load-use stall lasted more than one cycle");

    hold_freeze: assert property (@(posedge clk) disable iff (!rst_n)
        hold |=> $stable(wb_reg_write_enable) && $stable(wb_dest_reg_idx) &&
                 $stable(wb_reg_write_data))
    else report_error($sformatf("mismatch at %0t: write-back moved while held", $time));

    // hold comes in short random bursts
    task automatic next_hold(input logic allow);
        if (!allow) begin
            hold = 1'b0;
        end else if (hold_left > 0) begin
            hold = 1'b1;
            hold_left--;
        end else begin
            hold = 1'b0;
            if (($random(seed) & 15) == 0)
                hold_left = 1 + ($random(seed) & 3);
        end
    endtask

    // present one op and replay it until it is accepted
    task automatic issue_op(input logic no_op, input alu_op_t op, input reg_idx_t rs,
                            input reg_idx_t rt, input logic wr, input mem_ctl_t mc,
                            input reg_idx_t rd, input logic allow_hold);
        int waited;
        ex_no_op            = no_op;
        alu_op              = op;
        ex_rs_idx           = rs;
        ex_rt_idx           = rt;
        ex_reg_write_enable = wr;
        ex_mem_control      = mc;
        ex_dest_reg_idx     = rd;
        waited              = 0;
        do begin
            ex_rs_data = rf[rs];                            // refreshed on every replay
            ex_rt_data = rf[rt];
            @(negedge clk);
            next_hold(allow_hold);
            waited++;
        end while (!last_taken && waited < WAIT_MAX);
        if (!last_taken)
            report_error("operation never accepted, stall lasted too long");
    endtask

    // small register pool keeps dependencies dense
    // r1 holds the address mask and is never a destination
    function automatic reg_idx_t pick_reg();
        int r;
        r = $unsigned($random(seed)) % 7;
        return (r == 0) ? reg_idx_t'(0) : reg_idx_t'(r + 1);
    endfunction

    task automatic random_op();
        int       kind;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        kind = $unsigned($random(seed)) % 20;
        rs   = pick_reg();
        rt   = pick_reg();
        rd   = pick_reg();
        if (kind < 12)
            issue_op(1'b0, alu_op_t'($random(seed)), rs, rt, 1'b1, 2'b00, rd, 1'b1);
        else if (kind < 15)
            issue_op(1'b0, `ALU_OP_AND, 5'd1, rt, 1'b0, 2'b10, rd, 1'b1);   // store
        else if (kind < 18)
            issue_op(1'b0, `ALU_OP_AND, 5'd1, rt, 1'b1, 2'b01, rd, 1'b1);   // load
        else
            issue_op(1'b1, alu_op_t'($random(seed)), rs, rt, 1'b1,
                     mem_ctl_t'($random(seed)), rd, 1'b1);
    endtask

    initial begin
        int waited;
        seed                = 45695;
        rst_n               = 1'b0;
        hold                = 1'b0;
        ex_no_op            = 1'b1;
        alu_op              = '0;
        ex_rs_idx           = '0;
        ex_rt_idx           = '0;
        ex_rs_data          = '0;
        ex_rt_data          = '0;
        ex_reg_write_enable = 1'b0;
        ex_mem_control      = '0;
        ex_dest_reg_idx     = '0;
        held_last           = 1'b0;
        last_taken          = 1'b0;
        mem_live_load       = 1'b0;
        mem_dest            = '0;
        head_valid          = 1'b0;
        head_dest           = '0;
        head_data           = '0;
        hold_left           = 0;
        load_stalls         = 0;
        hold_cycles         = 0;
        for (int i = 0; i < 32; i++)
            rf[i] = $random(seed);
        rf[0] = '0;
        rf[1] = 32'h0000_003c;                      // word mask over 16 words
        for (int k = 0; k < 16; k++)
            rf[16 + k] = (rf[16 + k] & ~32'h3c) | (k << 2);   // one address per word
        for (int i = 0; i < 32; i++)
            arch_reg[i] = rf[i];

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int k = 0; k < 16; k++)                // fill every word the loads can reach
            issue_op(1'b0, `ALU_OP_AND, 5'd1, reg_idx_t'(16 + k), 1'b0, 2'b10, 5'd0, 1'b0);
        for (int n = 0; n < NUM_OPS; n++)
            random_op();

        hold                = 1'b0;
        ex_no_op            = 1'b1;
        ex_reg_write_enable = 1'b0;
        ex_mem_control      = '0;
        waited              = 0;
        while (dest_q.size() > 0 && waited < DRAIN_MAX) begin
            @(negedge clk);
            waited++;
        end

        if (dest_q.size() != 0)
            report_error("write-backs still missing after the pipeline drained");
        else if (load_stalls == 0 || hold_cycles == 0)
            report_error("stimulus never produced a load-use stall or a hold");
        else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

// File: vlog.f
+incdir+logic
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/alu.sv
logic/forwarding_unit.sv
logic/hazard_unit.sv
logic/ex_mem_reg.sv
logic/data_mem.sv
logic/mem_wb_reg.sv
logic/ex_mem_stages.sv
tests/ex_mem_stages_tb.sv

// File: Makefile
# Verilator build and run for the execute/memory pipeline half

VERILATOR ?= verilator
TOP       ?= ex_mem_stages_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q -F "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
